/* host_send_top.f */
design/host_send_pkg.sv
design/sync_fifo.sv
design/rr_arbiter.sv
design/send_regs.sv
design/send_splitter.sv
design/read_issue.sv
design/read_return.sv
design/host_send_top.sv
bench/pcie_read_model.sv
bench/tb_host_send.sv

/* bench/tb_host_send.sv */
//####################################################################
// Testbench for the host send path
// Reference page split per lane, line data and credit checks
//####################################################################

`timescale 1ns/100ps

module tb_host_send import host_send_pkg::*; ();

	localparam int NREQ = 6;

	typedef struct packed {
		logic [APP_W-1:0] lane;
		burst_desc_t      b;
	} issued_t;

	logic clk;
	logic rst;
	softreg_req_t softreg_req [NUM_APPS];
	softreg_resp_t softreg_resp [NUM_APPS];
	pcie_ar_t ar;
	logic arready;
	pcie_r_t r;
	logic rready;
	app_data_t app_data;
	logic app_ready;

	logic [ADDR_W-1:0] bases [NUM_APPS];
	int req_lines [NUM_APPS][NREQ];
	logic req_is_last [NUM_APPS][NREQ];
	int lane_total [NUM_APPS];
	int line_idx [NUM_APPS];
	int cur_req [NUM_APPS];
	int cur_off [NUM_APPS];
	int outstanding [NUM_APPS];
	issued_t issued [$];
	int beat;
	int total_lines;
	int limit;
	int errors;
	int ars_checked;
	int lines_checked;
	logic stim_started;

	host_send_top uut (
		.clk(clk),
		.rst(rst),
		.softreg_req(softreg_req),
		.softreg_resp(softreg_resp),
		.ar(ar),
		.arready(arready),
		.r(r),
		.rready(rready),
		.app_data(app_data),
		.app_ready(app_ready)
	);

	pcie_read_model u_host_mem (
		.clk(clk),
		.rst(rst),
		.ar(ar),
		.arready(arready),
		.r(r),
		.rready(rready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_value(input string name, input int lane,
			input logic [63:0] got, input logic [63:0] want);
		assert (got === want) else begin
			errors++;
			$display("error %s lane %0d: got 0x%h expected 0x%h", name, lane, got, want);
		end
	endtask

	task automatic write_reg(input int lane, input logic [31:0] addr, input logic [63:0] data);
		softreg_req[lane] = '{valid: 1'b1, is_write: 1'b1, addr: addr, data: data};
		@(posedge clk);
		#1;
		softreg_req[lane].valid = 1'b0;
	endtask

	// Response must show up one cycle after the request and only then
	task automatic read_reg(input int lane, input logic [31:0] addr, output logic [63:0] data);
		softreg_req[lane] = '{valid: 1'b1, is_write: 1'b0, addr: addr, data: 64'h0};
		@(posedge clk);
		#1;
		softreg_req[lane].valid = 1'b0;
		check_value("softreg_resp.valid", lane, 64'(softreg_resp[lane].valid), 64'h1);
		data = softreg_resp[lane].data;
		@(posedge clk);
		#1;
		check_value("softreg_resp.valid", lane, 64'(softreg_resp[lane].valid), 64'h0);
	endtask

	function automatic int find_lane(input logic [ADDR_W-1:0] addr);
		int hit;
		hit = -1;
		for (int i = 0; i < NUM_APPS; i++) begin
			if (bases[i][ADDR_W-1:IDX_W+6] == addr[ADDR_W-1:IDX_W+6])
				hit = i;
		end
		return hit;
	endfunction

	// Next burst of a lane: the remaining length cut at the page end
	task automatic expect_burst(input int lane, output burst_desc_t b);
		int left;
		int room;
		int n;
		left = req_lines[lane][cur_req[lane]] - cur_off[lane];
		room = PAGE_LINES - (line_idx[lane] % PAGE_LINES);
		n = (left < room) ? left : room;
		b.addr = {bases[lane][ADDR_W-1:IDX_W+6], IDX_W'(line_idx[lane]), 6'b0};
		b.len = LEN_W'(n - 1);
		b.last = (n == left) && req_is_last[lane][cur_req[lane]];
		line_idx[lane] = (line_idx[lane] + n) % (1 << IDX_W);
		if (n == left) begin
			cur_req[lane]++;
			cur_off[lane] = 0;
		end else begin
			cur_off[lane] += n;
		end
	endtask

	always @(posedge clk) begin : monitor
		int lane;
		burst_desc_t b;
		issued_t head;
		logic [ADDR_W-1:0] addr;
		logic at_end;

		if (!rst && !stim_started) begin
			check_value("ar.valid", 0, 64'(ar.valid), 64'h0);
			check_value("app_data.valid", 0, 64'(app_data.valid), 64'h0);
			check_value("rready", 0, 64'(rready), 64'h1);
			for (int i = 0; i < NUM_APPS; i++)
				check_value("softreg_resp.valid", i, 64'(softreg_resp[i].valid), 64'h0);
		end

		if (!rst && app_data.valid && app_ready) begin
			if (issued.size() == 0) begin
				errors++;
				$display("a line was delivered with no burst outstanding");
			end else begin
				head = issued[0];
				lane = int'(head.lane);
				at_end = beat == int'(head.b.len);
				addr = head.b.addr + ADDR_W'(beat * 64);
				check_value("app_data.sel", lane, 64'(app_data.sel), 64'(head.lane));
				check_value("app_data.burst_last", lane, 64'(app_data.burst_last), 64'(at_end));
				check_value("app_data.req_last", lane, 64'(app_data.req_last),
					64'(at_end && head.b.last));
				assert (app_data.data === {8{16'h0, addr}}) else begin
					errors++;
					$display("error app_data.data lane %0d: got 0x%h expected 0x%h",
						lane, app_data.data, {8{16'h0, addr}});
				end
				lines_checked++;
				if (at_end) begin
					void'(issued.pop_front());
					outstanding[lane]--;
					beat = 0;
				end else begin
					beat++;
				end
			end
		end

		if (!rst && ar.valid && arready) begin
			lane = find_lane(ar.addr);
			if (lane < 0) begin
				errors++;
				$display("AR address 0x%h belongs to no lane", ar.addr);
			end else if (cur_req[lane] >= NREQ) begin
				errors++;
				$display("lane %0d issued an AR beyond its queued requests", lane);
			end else begin
				expect_burst(lane, b);
				check_value("ar.addr", lane, 64'(ar.addr), 64'(b.addr));
				check_value("ar.len", lane, 64'(ar.len), 64'(b.len));
				assert (int'(ar.addr[11:6]) + int'(ar.len) < PAGE_LINES) else begin
					errors++;
					$display("AR at 0x%h with length %0d crosses a 4 KB page", ar.addr, ar.len);
				end
				issued.push_back('{lane: APP_W'(lane), b: b});
				outstanding[lane]++;
				assert (outstanding[lane] <= 16) else begin
					errors++;
					$display("lane %0d has %0d bursts outstanding, above the limit of 16",
						lane, outstanding[lane]);
				end
				ars_checked++;
			end
		end
	end

	// Random stalls on app_ready, some of them long
	initial begin : ready_driver
		int stall;
		stall = 0;
		app_ready = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			if (stall > 0) begin
				stall--;
				app_ready = 1'b0;
			end else if ($urandom_range(127, 0) == 0) begin
				stall = $urandom_range(167, 40);
				app_ready = 1'b0;
			end else begin
				app_ready = $urandom_range(7, 0) != 0;
			end
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, errors %0d, ARs checked %0d, lines checked %0d",
			cycles, errors, ars_checked, lines_checked);
		$display("TEST FAILED");
		$finish;
	end

	initial begin : main
		logic [63:0] data;

		void'($urandom(32'hf1d7));
		rst = 1'b1;
		stim_started = 1'b0;
		errors = 0;
		ars_checked = 0;
		lines_checked = 0;
		beat = 0;
		total_lines = 0;
		limit = 0;
		for (int l = 0; l < NUM_APPS; l++) begin
			softreg_req[l] = '0;
			// Lanes 10 MB apart, low bits ignored by the splitter
			bases[l] = 48'h0c00_0000_0000 + ADDR_W'(l) * 48'h0a0_0000 + 48'h1a40;
			lane_total[l] = 0;
			line_idx[l] = 0;
			cur_req[l] = 0;
			cur_off[l] = 0;
			outstanding[l] = 0;
			for (int k = 0; k < NREQ; k++) begin
				req_lines[l][k] = (l == 0 && k == 0) ? 1200 : $urandom_range(256, 1);
				req_is_last[l][k] = $urandom_range(1, 0);
				lane_total[l] += req_lines[l][k];
			end
			total_lines += lane_total[l];
		end
		limit = total_lines * 8 + 2000;

		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		stim_started = 1'b1;

		for (int l = 0; l < NUM_APPS; l++) begin
			write_reg(l, REG_SEND_ADDR, 64'(bases[l]));
			read_reg(l, REG_SEND_ADDR, data);
			check_value("softreg_resp.data", l, data, 64'(bases[l]));
		end
		for (int k = 0; k < NREQ; k++) begin
			for (int l = 0; l < NUM_APPS; l++)
				write_reg(l, REG_SEND_REQ,
					{48'd0, IDX_W'(req_lines[l][k] - 1), req_is_last[l][k]});
		end

		wait (lines_checked == total_lines);
		repeat (4) @(posedge clk);
		#1;

		// Credits since the address write, then cleared by the read
		for (int l = 0; l < NUM_APPS; l++) begin
			read_reg(l, REG_SEND_REQ, data);
			check_value("softreg_resp.data", l, data,
				{42'd0, 6'(NREQ), 16'(lane_total[l])});
			read_reg(l, REG_SEND_REQ, data);
			check_value("softreg_resp.data", l, data, 64'h0);
			check_value("requests split", l, 64'(cur_req[l]), 64'(NREQ));
		end
		check_value("unfinished bursts", 0, 64'(issued.size()), 64'h0);

		$display("errors %0d, ARs checked %0d, lines checked %0d",
			errors, ars_checked, lines_checked);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* bench/pcie_read_model.sv */
//####################################################################
// Host memory model for PCIe read bursts
// Each beat returns its own byte address repeated across the line
//####################################################################

`timescale 1ns/100ps

module pcie_read_model import host_send_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  pcie_ar_t ar,
	output logic     arready,
	output pcie_r_t  r,
	input  logic     rready
);

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [LEN_W-1:0]  len;
	} burst_t;

	burst_t pending [$];
	int beat;

	initial begin
		arready = 1'b0;
		r = '0;
		beat = 0;
	end

	always @(posedge clk) begin : respond
		logic in_rst;
		logic held;
		logic [ADDR_W-1:0] addr;

		in_rst = rst;
		held = r.valid && !rready;
		if (in_rst) begin
			pending.delete();
			beat = 0;
		end else begin
			if (ar.valid && arready)
				pending.push_back('{addr: ar.addr, len: ar.len});
			if (r.valid && rready) begin
				if (r.last) begin
					void'(pending.pop_front());
					beat = 0;
				end else begin
					beat++;
				end
			end
		end

		#1;
		// Random pauses on both channels
		arready = !in_rst && $urandom_range(3, 0) != 0;
		if (in_rst) begin
			r = '0;
		end else if (!held) begin
			if (pending.size() > 0 && $urandom_range(3, 0) != 0) begin
				addr = pending[0].addr + ADDR_W'(beat * 64);
				r.valid = 1'b1;
				r.data = {8{16'h0, addr}};
				r.last = beat == int'(pending[0].len);
			end else begin
				r.valid = 1'b0;
			end
		end
	end

endmodule

/* design/host_send_top.sv */
//####################################################################
// Host send path top
// Four application lanes sharing one PCIe read engine
//####################################################################

`timescale 1ns/100ps

module host_send_top import host_send_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	input  softreg_req_t  softreg_req [NUM_APPS],
	output softreg_resp_t softreg_resp [NUM_APPS],
	output pcie_ar_t      ar,
	input  logic          arready,
	input  pcie_r_t       r,
	output logic          rready,
	output app_data_t     app_data,
	input  logic          app_ready
);

	burst_desc_t desc [NUM_APPS];
	logic [NUM_APPS-1:0] desc_empty;
	logic [NUM_APPS-1:0] desc_pop;
	logic meta_wr;
	logic meta_full;
	burst_meta_t meta;
	logic [NUM_APPS-1:0] line_done;
	logic [NUM_APPS-1:0] burst_done;

	for (genvar i = 0; i < NUM_APPS; i++) begin : lane
		logic [ADDR_W-1:0] ring_base;
		logic lane_rst;
		logic push;
		send_req_t push_data;
		logic req_done;

		send_regs u_regs (
			.clk(clk),
			.rst(rst),
			.req(softreg_req[i]),
			.resp(softreg_resp[i]),
			.ring_base(ring_base),
			.lane_rst(lane_rst),
			.push(push),
			.push_data(push_data),
			.req_done(req_done),
			.line_done(line_done[i])
		);

		send_splitter u_split (
			.clk(clk),
			.rst(rst),
			.lane_rst(lane_rst),
			.push(push),
			.push_data(push_data),
			.ring_base(ring_base),
			.burst_done(burst_done[i]),
			.desc(desc[i]),
			.desc_empty(desc_empty[i]),
			.desc_pop(desc_pop[i]),
			.req_done(req_done)
		);
	end

	read_issue u_issue (
		.clk(clk),
		.rst(rst),
		.desc(desc),
		.desc_empty(desc_empty),
		.desc_pop(desc_pop),
		.ar(ar),
		.arready(arready),
		.meta_full(meta_full),
		.meta_wr(meta_wr),
		.meta(meta)
	);

	read_return u_return (
		.clk(clk),
		.rst(rst),
		.meta_wr(meta_wr),
		.meta(meta),
		.meta_full(meta_full),
		.r(r),
		.rready(rready),
		.app_data(app_data),
		.app_ready(app_ready),
		.line_done(line_done),
		.burst_done(burst_done)
	);

endmodule

/* design/read_return.sv */
//####################################################################
// PCIe read return
// Steers returned lines to their application by burst metadata
//####################################################################

`timescale 1ns/100ps

module read_return import host_send_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic                meta_wr,
	input  burst_meta_t         meta,
	output logic                meta_full,
	input  pcie_r_t             r,
	output logic                rready,
	output app_data_t           app_data,
	input  logic                app_ready,
	output logic [NUM_APPS-1:0] line_done,
	output logic [NUM_APPS-1:0] burst_done
);

	burst_meta_t mq;
	logic m_empty;
	logic m_rd;
	logic d_full;
	logic d_empty;
	logic [LINE_W:0] dq;
	logic [LEN_W-1:0] beat;
	logic take;

	sync_fifo #(
		.WIDTH($bits(burst_meta_t)),
		.LOG_DEPTH(META_LD)
	) u_meta_fifo (
		.clk(clk),
		.rst(rst),
		.wr(meta_wr),
		.wdata(meta),
		.full(meta_full),
		.q(mq),
		.empty(m_empty),
		.rd(m_rd)
	);

	// rlast rides along with the line for checking
	sync_fifo #(
		.WIDTH(LINE_W + 1),
		.LOG_DEPTH(DATA_LD)
	) u_data_fifo (
		.clk(clk),
		.rst(rst),
		.wr(r.valid && rready),
		.wdata({r.last, r.data}),
		.full(d_full),
		.q(dq),
		.empty(d_empty),
		.rd(take)
	);

	assign rready = !d_full;

	assign app_data.valid = !d_empty && !m_empty;
	assign app_data.sel = mq.sel;
	assign app_data.data = dq[LINE_W-1:0];
	assign app_data.burst_last = beat == mq.len;
	// Marks only the final line of a request
	assign app_data.req_last = app_data.burst_last && mq.last;

	assign take = app_data.valid && app_ready;
	assign m_rd = take && app_data.burst_last;

	always_ff @(posedge clk) begin
		if (rst)
			beat <= '0;
		else if (take)
			beat <= app_data.burst_last ? '0 : beat + 1'b1;
	end

	always_comb begin
		line_done = '0;
		burst_done = '0;
		line_done[mq.sel] = take;
		burst_done[mq.sel] = m_rd;
	end

	assert property (@(posedge clk) disable iff (rst)
		app_data.valid |-> dq[LINE_W] == app_data.burst_last);

	// Data never returns for a burst that was not issued
	assert property (@(posedge clk) disable iff (rst) !d_empty |-> !m_empty);

endmodule

/* design/read_issue.sv */
//####################################################################
// PCIe read-address issue
// Arbitrates lane descriptors and records each burst's owner
//####################################################################

`timescale 1ns/100ps

module read_issue import host_send_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  burst_desc_t         desc [NUM_APPS],
	input  logic [NUM_APPS-1:0] desc_empty,
	output logic [NUM_APPS-1:0] desc_pop,
	output pcie_ar_t            ar,
	input  logic                arready,
	input  logic                meta_full,
	output logic                meta_wr,
	output burst_meta_t         meta
);

	logic arb_ready;
	logic [APP_W-1:0] sel;
	logic accept;

	assign arb_ready = arready && !meta_full;

	rr_arbiter u_arb (
		.clk(clk),
		.rst(rst),
		.ready(arb_ready),
		.reqs(~desc_empty),
		.sel(sel)
	);

	assign ar.valid = !desc_empty[sel] && !meta_full;
	assign ar.addr = desc[sel].addr;
	assign ar.len = desc[sel].len;

	assign accept = ar.valid && arready;

	always_comb begin
		desc_pop = '0;
		if (accept)
			desc_pop[sel] = 1'b1;
	end

	// Owner and length follow the burst to the return side
	assign meta_wr = accept;
	assign meta.sel = sel;
	assign meta.len = desc[sel].len;
	assign meta.last = desc[sel].last;

	// Any waiting descriptor must land on a selected lane
	assert property (@(posedge clk) disable iff (rst)
		desc_empty != '1 && !meta_full |-> ar.valid);

	// The pointer must not rotate away while a request is offered
	assert property (@(posedge clk) disable iff (rst)
		ar.valid && !arready |=> ar.valid);

endmodule

/* design/send_splitter.sv */
//####################################################################
// Send request queue and page splitter
// Cuts requests into 4 KB bounded bursts under a 16-burst throttle
//####################################################################

`timescale 1ns/100ps

module send_splitter import host_send_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              lane_rst,
	input  logic              push,
	input  send_req_t         push_data,
	input  logic [ADDR_W-1:0] ring_base,
	input  logic              burst_done,
	output burst_desc_t       desc,
	output logic              desc_empty,
	input  logic              desc_pop,
	output logic              req_done
);

	send_req_t rq_q;
	logic rq_empty;
	logic df_full;
	logic [IDX_W-1:0] idx;
	logic [IDX_W-1:0] len_done;
	logic [IDX_W-1:0] len_left;
	logic [LEN_W-1:0] page_len;
	logic last_burst;
	logic [LEN_W-1:0] len;
	logic produce;
	logic [SEND_LD:0] throttle;
	burst_desc_t desc_in;

	// Host software must not overrun the queue
	sync_fifo #(
		.WIDTH($bits(send_req_t)),
		.LOG_DEPTH(REQ_LD)
	) u_req_fifo (
		.clk(clk),
		.rst(rst),
		.wr(push),
		.wdata(push_data),
		.full(),
		.q(rq_q),
		.empty(rq_empty),
		.rd(req_done)
	);

	// Lengths are all kept as count minus one
	assign len_left = rq_q.len - len_done;
	assign page_len = LEN_W'(PAGE_LINES - 1) - idx[LEN_W-1:0];
	assign last_burst = len_left <= IDX_W'(page_len);
	assign len = last_burst ? len_left[LEN_W-1:0] : page_len;

	assign produce = !rq_empty && !df_full && throttle != '0;
	assign req_done = produce && last_burst;

	assign desc_in.addr = {ring_base[ADDR_W-1:IDX_W+6], idx, 6'b0};
	assign desc_in.len = len;
	assign desc_in.last = last_burst && rq_q.last;

	sync_fifo #(
		.WIDTH($bits(burst_desc_t)),
		.LOG_DEPTH(SEND_LD)
	) u_desc_fifo (
		.clk(clk),
		.rst(rst),
		.wr(produce),
		.wdata(desc_in),
		.full(df_full),
		.q(desc),
		.empty(desc_empty),
		.rd(desc_pop)
	);

	always_ff @(posedge clk) begin
		if (rst || lane_rst) begin
			idx <= '0;
			len_done <= '0;
			throttle <= (SEND_LD + 1)'(1 << SEND_LD);
		end else begin
			if (produce) begin
				idx <= idx + len + 1'b1;
				len_done <= last_burst ? '0 : len_done + len + 1'b1;
			end
			throttle <= throttle + burst_done - produce;
		end
	end

	// A completion without an issued burst would push this past the limit
	assert property (@(posedge clk) disable iff (rst)
		throttle <= (SEND_LD + 1)'(1 << SEND_LD));

endmodule

/* design/send_regs.sv */
//####################################################################
// Per-application soft registers
// Ring address, send request queueing and read-to-clear credits
//####################################################################

`timescale 1ns/100ps

module send_regs import host_send_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  softreg_req_t      req,
	output softreg_resp_t     resp,
	output logic [ADDR_W-1:0] ring_base,
	output logic              lane_rst,
	output logic              push,
	output send_req_t         push_data,
	input  logic              req_done,
	input  logic              line_done
);

	logic rd;
	logic wr;
	logic clr;
	logic [5:0] req_cred;
	logic [15:0] line_cred;

	assign rd = req.valid && !req.is_write;
	assign wr = req.valid && req.is_write;

	assign lane_rst = wr && req.addr == REG_SEND_ADDR;
	assign push = wr && req.addr == REG_SEND_REQ;
	assign push_data = '{len: req.data[15:1], last: req.data[0]};

	// Reading the request register hands the credits to software
	assign clr = rd && req.addr == REG_SEND_REQ;

	always_ff @(posedge clk) begin
		if (lane_rst)
			ring_base <= req.data[ADDR_W-1:0];
	end

	always_ff @(posedge clk) begin
		if (rst || lane_rst) begin
			req_cred <= '0;
			line_cred <= '0;
		end else begin
			// Same-cycle increment survives the clear
			req_cred <= (clr ? 6'd0 : req_cred) + req_done;
			line_cred <= (clr ? 16'd0 : line_cred) + line_done;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			resp.valid <= 1'b0;
		else
			resp.valid <= rd;
	end

	always_ff @(posedge clk) begin
		if (rd) begin
			case (req.addr)
				REG_SEND_ADDR: resp.data <= {{(64 - ADDR_W){1'b0}}, ring_base};
				REG_SEND_REQ: resp.data <= {42'd0, req_cred, line_cred};
				default: resp.data <= '0;
			endcase
		end
	end

	// Credits must be drained before they wrap
	assert property (@(posedge clk) disable iff (rst)
		req_done && !clr && !lane_rst |-> req_cred != '1);
	assert property (@(posedge clk) disable iff (rst)
		line_done && !clr && !lane_rst |-> line_cred != '1);

endmodule

/* design/rr_arbiter.sv */
//####################################################################
// Four-way rotating-priority selector
//####################################################################

`timescale 1ns/100ps

module rr_arbiter import host_send_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic                ready,
	input  logic [NUM_APPS-1:0] reqs,
	output logic [APP_W-1:0]    sel
);

	logic [APP_W-1:0] prio;

	always_ff @(posedge clk) begin
		if (rst)
			prio <= '0;
		else if (ready)
			prio <= prio + 1'b1;
	end

	// Scan from the far end so the nearest requester wins
	always_comb begin
		logic [APP_W-1:0] idx;
		sel = prio;
		for (int i = NUM_APPS - 1; i >= 0; i--) begin
			idx = prio + APP_W'(i);
			if (reqs[idx])
				sel = idx;
		end
	end

endmodule

/* design/sync_fifo.sv */
//####################################################################
// Synchronous FIFO with show-ahead read
//####################################################################

`timescale 1ns/100ps

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int LOG_DEPTH = 4
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             wr,
	input  logic [WIDTH-1:0] wdata,
	output logic             full,
	output logic [WIDTH-1:0] q,
	output logic             empty,
	input  logic             rd
);

	logic [WIDTH-1:0] mem [1 << LOG_DEPTH];
	logic [LOG_DEPTH-1:0] wr_ptr;
	logic [LOG_DEPTH-1:0] rd_ptr;
	logic [LOG_DEPTH:0] count;

	// Count reaches depth exactly when the top bit sets
	assign full = count[LOG_DEPTH];
	assign empty = count == '0;
	assign q = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr, rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (rst) wr |-> !full);
	assert property (@(posedge clk) disable iff (rst) rd |-> !empty);

endmodule

/* design/host_send_pkg.sv */
//####################################################################
// Host send path package
// Widths, register offsets and channel structs
//####################################################################

package host_send_pkg;

	localparam int NUM_APPS = 4;
	localparam int APP_W = 2;
	localparam int LINE_W = 512;
	localparam int ADDR_W = 48;
	// Line index within the 2 MB ring
	localparam int IDX_W = 15;
	localparam int PAGE_LINES = 64;
	// Beat count minus one
	localparam int LEN_W = 6;
	localparam int SEND_LD = 4;
	localparam int META_LD = 6;
	localparam int DATA_LD = 6;
	localparam int REQ_LD = 5;

	typedef enum logic [31:0] {
		REG_SEND_ADDR = 32'h10,
		REG_SEND_REQ  = 32'h18
	} reg_addr_e;

	typedef struct packed {
		logic        valid;
		logic        is_write;
		logic [31:0] addr;
		logic [63:0] data;
	} softreg_req_t;

	typedef struct packed {
		logic        valid;
		logic [63:0] data;
	} softreg_resp_t;

	// Total length minus one
	typedef struct packed {
		logic [IDX_W-1:0] len;
		logic             last;
	} send_req_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [LEN_W-1:0]  len;
		logic              last;
	} burst_desc_t;

	typedef struct packed {
		logic [APP_W-1:0] sel;
		logic [LEN_W-1:0] len;
		logic             last;
	} burst_meta_t;

	typedef struct packed {
		logic              valid;
		logic [ADDR_W-1:0] addr;
		logic [LEN_W-1:0]  len;
	} pcie_ar_t;

	typedef struct packed {
		logic              valid;
		logic [LINE_W-1:0] data;
		logic              last;
	} pcie_r_t;

	typedef struct packed {
		logic              valid;
		logic [APP_W-1:0]  sel;
		logic [LINE_W-1:0] data;
		logic              burst_last;
		logic              req_last;
	} app_data_t;

endpackage
